/* logic/hub_ctrl.sv */
`default_nettype none
`include "trig_hub_config.svh"

module hub_ctrl
	import trig_hub_pkg::*;
(
	input  wire        CLK125,
	input  wire        reset_i,
	input  wire        enable_i,
	input  wire        inhibit_i,
	output logic       accept_o,
	output logic       core_rst_o,
	output hub_state_e state_o
);

	localparam int PU_W = $clog2(`POWERUP_CYCLES + 1);
	localparam logic [PU_W-1:0] PU_LAST = PU_W'(`POWERUP_CYCLES - 1);

	hub_state_e      state;
	hub_state_e      run_state;        // Target once the hold is over
	logic [PU_W-1:0] pu_cnt;           // Clocks spent in the hold

	// Enable low beats inhibit
	always_comb begin
		if (!enable_i)
			run_state = ST_DISABLED;
		else if (inhibit_i)
			run_state = ST_INHIBIT;
		else
			run_state = ST_ARMED;
	end

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			state  <= ST_POWERUP;
			pu_cnt <= '0;
		end else begin
			case (state)
				ST_POWERUP: begin
					pu_cnt <= pu_cnt + 1'b1;
					if (pu_cnt == PU_LAST)
						state <= run_state;    // Hold done
				end
				default: state <= run_state;   // Track inputs one clock late
			endcase
		end
	end

	assign core_rst_o = (state == ST_POWERUP);
	assign accept_o   = (state == ST_ARMED);
	assign state_o    = state;

	////////////////////////////////////////////////////////////
	// Checks

	// No record may pass while the datapath is still held
	a_no_accept_in_rst: assert property (@(posedge CLK125) disable iff (reset_i)
		core_rst_o |-> !accept_o);

endmodule

`default_nettype wire

/* logic/led_stretch.sv */
`default_nettype none
`include "trig_hub_config.svh"

module led_stretch (
	input  wire  CLK125,
	input  wire  reset_i,
	input  wire  pulse_i,
	output logic led_o
);

	localparam int HOLD_W = $clog2(`LED_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;       // Clocks left to stay lit

	// A live pulse lights the LED even while the core is held in reset
	always_ff @(posedge CLK125) begin
		if (pulse_i)
			hold_cnt <= HOLD_W'(`LED_HOLD);   // Retrigger
		else if (reset_i)
			hold_cnt <= '0;
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign led_o = (hold_cnt != '0);

endmodule

`default_nettype wire

/* logic/token_queue.sv */
`default_nettype none
`include "trig_hub_config.svh"

module token_queue
	import trig_hub_pkg::*;
(
	input  wire                 CLK125,
	input  wire                 reset_i,
	input  wire                 accept_i,
	input  wire                 tok_rdy_i,
	input  wire                 tok_err_i,
	input  wire                 mem_credit_i,
	input  wire [`TOKEN_W-1:0]  token_i,
	output token_rec_t          rec_o,
	output logic                rec_valid_o,
	output logic                overflow_o
);

	localparam int PTR_W = $clog2(`TOKQ_DEPTH);
	localparam int CNT_W = $clog2(`TOKQ_DEPTH + 1);
	localparam int CR_W  = $clog2(`INIT_CREDITS + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`TOKQ_DEPTH - 1);

	token_rec_t        fifo_mem [`TOKQ_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  fill;           // Records waiting
	logic [CR_W-1:0]   credits;        // Free slots on memory side
	logic [`SEQ_W-1:0] seq;
	logic              take;           // Token arrived while armed
	logic              full;
	logic              push;
	logic              pop;

	assign take = tok_rdy_i & accept_i;
	assign full = (fill == CNT_W'(`TOKQ_DEPTH));
	assign push = take & ~full;
	assign pop  = (fill != '0) & (credits != '0);  // Send only against a credit

	always_ff @(posedge CLK125) begin
		if (push)
			fifo_mem[wr_ptr] <= '{err: tok_err_i, seq: seq, token: token_i};
	end

	////////////////////////////////////////////////////////////
	// Pointers, fill, sequence and credits

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fill        <= '0;
			seq         <= '0;
			credits     <= CR_W'(`INIT_CREDITS);
			overflow_o  <= 1'b0;
			rec_valid_o <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			fill <= fill + CNT_W'(push) - CNT_W'(pop);
			if (take)
				seq <= seq + 1'b1;           // Dropped records leave a gap
			if (take & full)
				overflow_o <= 1'b1;          // Sticky until reset
			credits     <= credits - CR_W'(pop) + CR_W'(mem_credit_i);
			rec_valid_o <= pop;
		end
	end

	always_ff @(posedge CLK125) begin
		if (pop)
			rec_o <= fifo_mem[rd_ptr];
	end

	// Every record sent was covered by a credit
	a_credit_send: assert property (@(posedge CLK125) disable iff (reset_i)
		rec_valid_o |-> $past(credits) != '0);

	// Memory never returns more than it granted
	a_credit_bound: assert property (@(posedge CLK125) disable iff (reset_i)
		credits <= CR_W'(`INIT_CREDITS));

endmodule

`default_nettype wire

/* logic/token_rx.sv */
`default_nettype none
`include "trig_hub_config.svh"

module token_rx
	import trig_hub_pkg::*;
(
	input  wire                      CLK125,
	input  wire                      reset_i,
	input  wire                      ser_trig_i,
	output link_word_t               link_o,
	output logic                     tok_rdy_o,
	output logic                     tok_err_o,
	output logic [`TOKEN_W-1:0]      token_o
);

	localparam int CNT_W = $clog2(`TOKEN_W + 2);
	localparam logic [CNT_W-1:0] PAR_BIT = CNT_W'(`TOKEN_W + 1);

	logic [CNT_W-1:0]    bit_cnt;      // Zero while idle and eleven at the parity bit
	logic [`TOKEN_W-1:0] shreg;        // Token bits MSB first
	logic                frame_end;    // Parity bit on the line now
	logic                par_err;

	assign frame_end = (bit_cnt == PAR_BIT);
	assign par_err   = ^{shreg, ser_trig_i};   // Odd ones over token plus parity

	////////////////////////////////////////////////////////////
	// Deserializer

	always_ff @(posedge CLK125) begin
		if (reset_i)
			bit_cnt <= '0;
		else if (frame_end)
			bit_cnt <= '0;                   // Back to idle
		else if (bit_cnt != '0 || ser_trig_i)
			bit_cnt <= bit_cnt + 1'b1;       // Start bit or next data bit
	end

	always_ff @(posedge CLK125) begin
		if (bit_cnt != '0 && !frame_end)
			shreg <= {shreg[`TOKEN_W-2:0], ser_trig_i};
	end

	////////////////////////////////////////////////////////////
	// Link framer

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			link_o    <= '{data: `COMMA_WORD, kchar: 1'b1};
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
		end else begin
			tok_rdy_o <= frame_end;
			tok_err_o <= frame_end & par_err;    // Only valid with tok_rdy
			if (frame_end)
				link_o <= '{data: {5'b10000, par_err, shreg}, kchar: 1'b0};
			else
				link_o <= '{data: `COMMA_WORD, kchar: 1'b1};  // Fill between tokens
		end
	end

	always_ff @(posedge CLK125) begin
		if (frame_end)
			token_o <= shreg;
	end

	// A data word on the link is always the one framed token
	a_kchar_tok: assert property (@(posedge CLK125) disable iff (reset_i)
		!link_o.kchar |-> tok_rdy_o && link_o.data[15:11] == 5'b10000);

endmodule

`default_nettype wire

/* logic/trig_hub_config.svh */
`ifndef TRIG_HUB_CONFIG_SVH
`define TRIG_HUB_CONFIG_SVH

// Token and record field widths
`define TOKEN_W          10
`define SEQ_W            5

// Hold after reset before the core runs
`define POWERUP_CYCLES   64

// Record FIFO towards event memory
`define TOKQ_DEPTH       8
`define INIT_CREDITS     4      // Granted by memory after reset

// Front-panel LED on-time in clocks
`define LED_HOLD         16

// Idle link word, K28.5 in the low byte
`define COMMA_WORD       16'h00BC

`endif

/* logic/trig_hub_pkg.sv */
`default_nettype none
`include "trig_hub_config.svh"

package trig_hub_pkg;

	// Record handed to event memory, 16 bits
	typedef struct packed {
		logic                err;      // Parity failed on the frame
		logic [`SEQ_W-1:0]   seq;      // Accepted record number, wraps
		logic [`TOKEN_W-1:0] token;    // Master trigger token
	} token_rec_t;

	// One word on the channel link
	typedef struct packed {
		logic [15:0] data;
		logic        kchar;            // Set for comma, clear for token
	} link_word_t;

	// Controller states
	typedef enum logic [1:0] {
		ST_POWERUP  = 2'd0,            // Core held in reset
		ST_DISABLED = 2'd1,            // Enable bit low
		ST_ARMED    = 2'd2,            // Records go to memory
		ST_INHIBIT  = 2'd3             // Inhibit line high
	} hub_state_e;

endpackage

`default_nettype wire

/* logic/trig_hub_top.sv */
`default_nettype none
`include "trig_hub_config.svh"

module trig_hub_top (
	input  wire                      CLK125,
	input  wire                      reset_i,
	input  wire                      ser_trig_i,
	input  wire                      enable_i,
	input  wire                      inhibit_i,
	input  wire                      mem_credit_i,
	output trig_hub_pkg::link_word_t link_o,
	output trig_hub_pkg::token_rec_t rec_o,
	output wire                      rec_valid_o,
	output wire [2:0]                led_o
);

	wire                        accept;     // Armed, records go to memory
	wire                        core_rst;   // Power-up hold
	trig_hub_pkg::hub_state_e   hub_state;
	wire                        tok_rdy;
	wire                        tok_err;
	wire [`TOKEN_W-1:0]         token;
	wire                        overflow;   // Record FIFO lost a token

	hub_ctrl u_hub_ctrl (
		.CLK125     (CLK125),
		.reset_i    (reset_i),
		.enable_i   (enable_i),
		.inhibit_i  (inhibit_i),
		.accept_o   (accept),
		.core_rst_o (core_rst),
		.state_o    (hub_state)
	);

	////////////////////////////////////////////////////////////
	// Token path, serial in to link and memory

	token_rx u_token_rx (
		.CLK125     (CLK125),
		.reset_i    (core_rst),
		.ser_trig_i (ser_trig_i),
		.link_o     (link_o),
		.tok_rdy_o  (tok_rdy),
		.tok_err_o  (tok_err),
		.token_o    (token)
	);

	token_queue u_token_queue (
		.CLK125       (CLK125),
		.reset_i      (core_rst),
		.accept_i     (accept),
		.tok_rdy_i    (tok_rdy),
		.tok_err_i    (tok_err),
		.mem_credit_i (mem_credit_i),
		.token_i      (token),
		.rec_o        (rec_o),
		.rec_valid_o  (rec_valid_o),
		.overflow_o   (overflow)
	);

	////////////////////////////////////////////////////////////
	// Front-panel LEDs

	led_stretch u_led_err (             // Yellow, trouble or reset
		.CLK125  (CLK125),
		.reset_i (core_rst),
		.pulse_i (tok_err | overflow | core_rst),
		.led_o   (led_o[0])
	);

	led_stretch u_led_tok (             // Master trigger seen
		.CLK125  (CLK125),
		.reset_i (core_rst),
		.pulse_i (tok_rdy),
		.led_o   (led_o[1])
	);

	led_stretch u_led_arm (
		.CLK125  (CLK125),
		.reset_i (core_rst),
		.pulse_i (hub_state == trig_hub_pkg::ST_ARMED),
		.led_o   (led_o[2])
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the trigger hub testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f tb.f --top-module trig_hub_tb -o trig_hub_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/trig_hub_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* tb.f */
+incdir+logic
logic/trig_hub_pkg.sv
logic/hub_ctrl.sv
logic/token_rx.sv
logic/token_queue.sv
logic/led_stretch.sv
logic/trig_hub_top.sv
verif/trig_hub_tb.sv

/* verif/trig_hub_patterns.txt */
# token_hex corrupt_parity expected_err
# one frame per line, sent in this order
000 0 0
3FF 0 0
155 0 0
2AA 1 1
001 0 0
200 0 0
0F0 1 1
30C 0 0
1E7 0 0
3FE 1 1
081 0 0
2D4 0 0
07F 0 0
100 1 1
36A 0 0
0C3 0 0

/* verif/trig_hub_tb.sv */
`default_nettype none
`include "trig_hub_config.svh"

module trig_hub_tb
	import trig_hub_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 200;       // Clocks any one wait may take

	logic       CLK125;
	logic       reset_i;
	logic       ser_trig_i;
	logic       enable_i;
	logic       inhibit_i;
	logic       mem_credit_i;
	link_word_t link_o;
	token_rec_t rec_o;
	logic       rec_valid_o;
	logic [2:0] led_o;

	logic [`TOKEN_W-1:0] pat_tok [32];
	logic                pat_bad [32];     // Parity inverted on the wire
	logic                pat_err [32];     // Error bit the link should show
	int                  n_pat;
	token_rec_t          rec_q [$];        // Seen at the memory port
	token_rec_t          exp_q [$];
	logic [`SEQ_W-1:0]   exp_seq;
	int                  owed;             // Credits memory still has to return
	logic                hold_credits = 1'b0;

	trig_hub_top u_trig_hub_top (
		.CLK125       (CLK125),
		.reset_i      (reset_i),
		.ser_trig_i   (ser_trig_i),
		.enable_i     (enable_i),
		.inhibit_i    (inhibit_i),
		.mem_credit_i (mem_credit_i),
		.link_o       (link_o),
		.rec_o        (rec_o),
		.rec_valid_o  (rec_valid_o),
		.led_o        (led_o)
	);

	initial begin
		CLK125 = 1'b0;
		forever #10 CLK125 = ~CLK125;      // 20 ns
	end

	// Memory model returns one credit per record taken
	initial begin
		owed = 0;
		mem_credit_i <= 1'b0;
		forever begin
			@(posedge CLK125);
			if (!hold_credits && owed > 0) begin
				mem_credit_i <= 1'b1;
				owed = owed - 1;
			end else
				mem_credit_i <= 1'b0;
			if (rec_valid_o === 1'b1) begin  // Values from before the edge
				rec_q.push_back(rec_o);
				owed = owed + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and waits

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_link(input string name, input link_word_t exp, input link_word_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected data=%h kchar=%b, actual data=%h kchar=%b",
				name, exp.data, exp.kchar, act.data, act.kchar);
			stop_run();
		end
	endtask

	task automatic check_rec(input string name, input token_rec_t exp, input token_rec_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected err=%b seq=%0d token=%h, actual err=%b seq=%0d token=%h",
				name, exp.err, exp.seq, exp.token, act.err, act.seq, act.token);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic wait_led(input int idx, input logic lit, input int limit);
		int t = 0;
		while (led_o[idx] !== lit) begin
			if (t == limit) begin
				$display("LED %0d did not change to %b within %0d clocks", idx, lit, limit);
				stop_run();
			end
			t++;
			@(negedge CLK125);
		end
	endtask

	task automatic wait_records(input int n);
		int t = 0;
		while (rec_q.size() < n) begin
			if (t == WAIT_LIMIT) begin
				$display("Only %0d of %0d records reached memory", rec_q.size(), n);
				stop_run();
			end
			t++;
			@(negedge CLK125);
		end
	endtask

	task automatic wait_credits_back();
		int t = 0;
		while (owed != 0) begin
			if (t == WAIT_LIMIT) begin
				$display("Memory model could not return its credits");
				stop_run();
			end
			t++;
			@(negedge CLK125);
		end
	endtask

	task automatic expect_record(input string name);
		wait_records(1);
		check_rec(name, exp_q.pop_front(), rec_q.pop_front());
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	task automatic load_patterns();
		int                  fd;
		string               line;
		logic [`TOKEN_W-1:0] tok;
		logic                bad;
		logic                err;
		fd = $fopen("verif/trig_hub_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/trig_hub_patterns.txt");
			stop_run();
		end
		n_pat = 0;
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 5 || line[0] == "#")
				continue;                      // Column notes and blank lines
			if ($sscanf(line, "%h %b %b", tok, bad, err) != 3 || n_pat == 32) begin
				$display("Bad or surplus line in the pattern file: %s", line);
				stop_run();
			end
			pat_tok[n_pat] = tok;
			pat_bad[n_pat] = bad;
			pat_err[n_pat] = err;
			n_pat++;
		end
		$fclose(fd);
	endtask

	task automatic send_frame(input logic [`TOKEN_W-1:0] tok, input logic bad);
		logic par;
		par = (^tok) ^ bad;                    // Even ones over token and parity
		repeat (2 + $urandom % 4) @(posedge CLK125);  // Idle gap of two or more clocks
		ser_trig_i <= 1'b1;                    // Start
		for (int i = `TOKEN_W - 1; i >= 0; i--) begin
			@(posedge CLK125);
			ser_trig_i <= tok[i];              // MSB first
		end
		@(posedge CLK125);
		ser_trig_i <= par;
		@(posedge CLK125);
		ser_trig_i <= 1'b0;
	endtask

	// Token word one clock after the parity bit and commas after it
	task automatic pass_token(input string name, input int idx, input logic accepted);
		link_word_t tok_word;
		link_word_t comma;
		token_rec_t exp_rec;
		tok_word = '{data: {5'b10000, pat_err[idx], pat_tok[idx]}, kchar: 1'b0};
		comma    = '{data: `COMMA_WORD, kchar: 1'b1};
		exp_rec  = '{err: pat_err[idx], seq: exp_seq, token: pat_tok[idx]};
		if (accepted) begin
			exp_q.push_back(exp_rec);
			exp_seq = exp_seq + 1'b1;          // Wraps at 32
		end
		send_frame(pat_tok[idx], pat_bad[idx]);
		@(negedge CLK125);                     // Parity bit taken at the last edge
		check_link(name, tok_word, link_o);
		@(negedge CLK125);
		check_link({name, "_comma"}, comma, link_o);
	endtask

	initial begin
		void'($urandom(53));
		reset_i    <= 1'b1;
		ser_trig_i <= 1'b0;
		enable_i   <= 1'b1;
		inhibit_i  <= 1'b0;
		exp_seq = '0;
		load_patterns();
		repeat (10) @(posedge CLK125);
		reset_i <= 1'b0;

		// Reset LED lit during the hold and dark after it
		@(negedge CLK125);
		check_bit("reset_led", 1'b1, led_o[0]);
		check_bit("reset_tok_led", 1'b0, led_o[1]);
		check_bit("reset_arm_led", 1'b0, led_o[2]);
		wait_led(2, 1'b1, `POWERUP_CYCLES + 8);
		wait_led(0, 1'b0, `LED_HOLD + 4);
		check_bit("idle_valid", 1'b0, rec_valid_o);
		repeat (4) begin
			check_link("idle_comma", '{data: `COMMA_WORD, kchar: 1'b1}, link_o);
			@(negedge CLK125);
		end

		// All patterns twice while armed so seq wraps
		for (int round = 0; round < 2; round++)
			for (int i = 0; i < n_pat; i++) begin
				pass_token("armed", i, 1'b1);
				expect_record("armed_rec");
				if (pat_err[i])
					check_bit("err_led", 1'b1, led_o[0]);
			end

		// Credits held back
		wait_credits_back();
		hold_credits = 1'b1;
		for (int i = 0; i < 6; i++)
			pass_token("held", i, 1'b1);
		wait_records(`INIT_CREDITS);
		repeat (30) @(negedge CLK125);
		check_count("held_records", `INIT_CREDITS, rec_q.size());
		hold_credits = 1'b0;
		for (int i = 0; i < 6; i++)
			expect_record("released_rec");    // In order with seq up by one

		////////////////////////////////////////////////////////////
		// Gating by enable and inhibit
		@(posedge CLK125);
		enable_i <= 1'b0;
		@(negedge CLK125);
		wait_led(2, 1'b0, `LED_HOLD + 4);
		pass_token("disabled", 0, 1'b0);
		repeat (10) @(negedge CLK125);
		check_count("disabled_records", 0, rec_q.size());
		@(posedge CLK125);
		enable_i  <= 1'b1;
		inhibit_i <= 1'b1;                     // Straight to inhibit without passing armed
		pass_token("inhibited", 3, 1'b0);
		repeat (10) @(negedge CLK125);
		check_count("inhibited_records", 0, rec_q.size());
		check_bit("inhibit_led", 1'b0, led_o[2]);
		@(posedge CLK125);
		inhibit_i <= 1'b0;
		@(negedge CLK125);
		wait_led(2, 1'b1, 4);

		// Seq resumes and the token LED lights then fades
		pass_token("rearmed", 2, 1'b1);
		check_bit("tok_led_on", 1'b1, led_o[1]);
		wait_led(1, 1'b0, `LED_HOLD + 2);
		expect_record("rearmed_rec");

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
